//--- Makefile
# Verilator build and run of the SIMD ALU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       := alu_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- compile.f
logic/alu_pkg.sv
logic/simd_adder.sv
logic/simd_shifter.sv
logic/simd_compare.sv
logic/bit_count.sv
logic/serial_divider.sv
logic/alu_top.sv
tb/alu_assertions.sv
tb/alu_tb.sv

//--- logic/alu_pkg.sv
/*
  alu_pkg
  shared widths, operator and lane-mode encodings, and the
  request and shift-control structs of the SIMD integer ALU
*/
`default_nettype none

package alu_pkg;

  // datapath geometry
  localparam int DATA_W = 32;
  localparam int LANES  = 4;
  localparam int CNT_W  = 6;

  // operator codes, grouped by the block that serves them
  typedef enum logic [5:0] {
    AND, OR, XOR,
    ADD, SUB,
    SLL, SRL, SRA, ROR,
    EQ, NE, GTS, GTU, GES, GEU, LTS, LTU, LES, LEU,
    SLTS, SLTU,
    MIN, MINU, MAX, MAXU,
    FF1, FL1, CNT, CLB,
    // division codes on a 4-aligned block
    // bit 0 selects signed, bit 1 selects remainder
    DIVU = 6'd32,
    DIV  = 6'd33,
    REMU = 6'd34,
    REM  = 6'd35
  } alu_op_e;

  // lane partitioning of the 32-bit word
  typedef enum logic [1:0] {
    MODE32 = 2'b00,
    MODE16 = 2'b10,
    MODE8  = 2'b11
  } vec_mode_e;

  typedef struct packed {
    alu_op_e           operator;
    vec_mode_e         vector_mode;
    logic [DATA_W-1:0] operand_a;
    logic [DATA_W-1:0] operand_b;
  } alu_req_t;

  // left also covers divisor prealignment, rotate is 32-bit only
  typedef struct packed {
    logic left;
    logic arith;
    logic rotate;
  } shift_ctrl_t;

  function automatic logic is_div_op(alu_op_e op);
    return op inside {DIVU, DIV, REMU, REM};
  endfunction

endpackage

`default_nettype wire

//--- logic/alu_top.sv
/*
  alu_top
  integer ALU of the execute stage, decodes the operator, steers
  the shared shifter between shifts and divisor alignment, and
  muxes the adder, shifter, compare, bit count and divider results
*/
`timescale 1ns/1ps
`default_nettype none

module alu_top import alu_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              enable_i,
  input  alu_req_t          req_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              comparison_result_o,
  output logic              ready_o
);

  alu_op_e                     op;
  logic [$bits(alu_op_e)-1:0]  op_code;
  logic [DATA_W-1:0]           op_a;
  logic [DATA_W-1:0]           op_b;
  logic                        is_div;
  logic                        div_req;
  shift_ctrl_t                 shift_ctrl;
  vec_mode_e                   shift_mode;
  logic [DATA_W-1:0]           shift_amt;
  logic [DATA_W-1:0]           sum;
  logic [DATA_W-1:0]           shift_result;
  logic [DATA_W-1:0]           shift_left_result;
  logic [LANES-1:0]            cmp_mask;
  logic [DATA_W-1:0]           cmp_spread;
  logic [DATA_W-1:0]           minmax;
  logic [CNT_W-1:0]            count;
  logic [CNT_W-1:0]            div_shift;
  logic                        div_zero;
  logic                        div_valid;
  logic [DATA_W-1:0]           div_result;

  assign op      = req_i.operator;
  assign op_code = req_i.operator;
  assign op_a    = req_i.operand_a;
  assign op_b    = req_i.operand_b;

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////
  assign is_div  = is_div_op(op);
  assign div_req = enable_i & is_div;

  // division borrows the left path to align the divisor
  assign shift_ctrl.left   = (op == SLL) || is_div;
  assign shift_ctrl.arith  = (op == SRA);
  assign shift_ctrl.rotate = (op == ROR);

  // alignment is a full-word shift by the leading-bit count
  assign shift_mode = is_div ? MODE32 : req_i.vector_mode;
  assign shift_amt  = div_req ? DATA_W'(div_shift) : op_b;

  simd_adder u_adder (
    .operand_a_i   (op_a),
    .operand_b_i   (op_b),
    .negate_i      (op == SUB),
    .vector_mode_i (req_i.vector_mode),
    .sum_o         (sum)
  );

  simd_shifter u_shifter (
    .operand_i     (op_a),
    .amount_i      (shift_amt),
    .ctrl_i        (shift_ctrl),
    .vector_mode_i (shift_mode),
    .result_o      (shift_result),
    .left_result_o (shift_left_result)
  );

  simd_compare u_compare (
    .operand_a_i   (op_a),
    .operand_b_i   (op_b),
    .operator_i    (op),
    .vector_mode_i (req_i.vector_mode),
    .cmp_mask_o    (cmp_mask),
    .minmax_o      (minmax)
  );

  bit_count u_bit_count (
    .operand_i      (op_a),
    .operator_i     (op),
    .count_o        (count),
    .div_shift_o    (div_shift),
    .operand_zero_o (div_zero)
  );

  // operands swapped, b is the dividend and aligned a the divisor
  serial_divider u_divider (
    .clk            (clk),
    .rst_i          (rst_i),
    .start_i        (div_req),
    .signed_i       (op_code[0]),
    .rem_i          (op_code[1]),
    .dividend_i     (op_b),
    .divisor_i      (shift_left_result),
    .shift_i        (div_shift),
    .divisor_zero_i (div_zero),
    .out_ready_i    (ex_ready_i),
    .valid_o        (div_valid),
    .result_o       (div_result)
  );

  //////////////////////////////////////////////////
  // result mux
  //////////////////////////////////////////////////
  for (genvar i = 0; i < LANES; i++) begin : g_spread
    assign cmp_spread[8*i +: 8] = {8{cmp_mask[i]}};
  end

  always_comb begin
    case (op)
      AND:                      result_o = op_a & op_b;
      OR:                       result_o = op_a | op_b;
      XOR:                      result_o = op_a ^ op_b;
      ADD, SUB:                 result_o = sum;
      SLL, SRL, SRA, ROR:       result_o = shift_result;
      EQ, NE, GTS, GTU, GES,
      GEU, LTS, LTU, LES, LEU:  result_o = cmp_spread;
      SLTS, SLTU:               result_o = DATA_W'(cmp_mask[LANES-1]);
      MIN, MINU, MAX, MAXU:     result_o = minmax;
      FF1, FL1, CNT, CLB:       result_o = DATA_W'(count);
      DIVU, DIV, REMU, REM:     result_o = div_result;
      default:                  result_o = '0;
    endcase
  end

  // top lane decides branches and set-less-than
  assign comparison_result_o = cmp_mask[LANES-1];

  // drops as soon as a division shows up, back high in finish
  assign ready_o = div_valid | ~div_req;

endmodule

`default_nettype wire

//--- logic/bit_count.sv
/*
  bit_count
  find-first-one, find-last-one, population count and
  count-leading-bits, plus the divisor alignment shift and
  zero-divisor flag for the serial divider
*/
`timescale 1ns/1ps
`default_nettype none

module bit_count import alu_pkg::*; (
  input  logic [DATA_W-1:0] operand_i,
  input  alu_op_e           operator_i,
  output logic [CNT_W-1:0]  count_o,
  output logic [CNT_W-1:0]  div_shift_o,
  output logic              operand_zero_o
);

  logic [DATA_W-1:0] op_rev;
  logic [DATA_W-1:0] op_inv_rev;
  logic [DATA_W-1:0] search;
  logic [4:0]        ff1;
  logic              no_one;
  logic [CNT_W-1:0]  popcnt;
  logic [CNT_W-1:0]  clb;
  logic              unsigned_div;

  assign op_rev     = {<<{operand_i}};
  assign op_inv_rev = {<<{~operand_i}};

  // reversed search finds the top one, inverted reversed finds the top zero
  always_comb begin
    case (operator_i)
      FF1:             search = operand_i;
      FL1, DIVU, REMU: search = op_rev;
      CLB, DIV, REM:   search = operand_i[DATA_W-1] ? op_inv_rev : op_rev;
      default:         search = '0;
    endcase
  end

  // scan down so the lowest set index is left in ff1
  always_comb begin
    ff1 = '0;
    for (int i = DATA_W - 1; i >= 0; i--) begin
      if (search[i]) ff1 = 5'(i);
    end
  end

  assign no_one = ~|search;

  always_comb begin
    popcnt = '0;
    for (int i = 0; i < DATA_W; i++) begin
      popcnt = popcnt + CNT_W'(operand_i[i]);
    end
  end

  // leading sign bits minus one, wraps to all ones when the top bit was hit
  assign clb = CNT_W'(ff1) - CNT_W'(1);

  always_comb begin
    case (operator_i)
      FF1:     count_o = no_one ? CNT_W'(32) : CNT_W'(ff1);
      FL1:     count_o = no_one ? CNT_W'(32) : CNT_W'(5'd31 - ff1);
      CNT:     count_o = popcnt;
      // zero gives 0, all ones gives 31
      CLB:     count_o = no_one ? (operand_i[DATA_W-1] ? CNT_W'(31) : '0) : clb;
      default: count_o = '0;
    endcase
  end

  // unsigned divisors go up to the leading one
  // signed ones stop one short so bit 31 keeps the sign
  assign unsigned_div = operator_i inside {DIVU, REMU};
  assign div_shift_o  = (no_one ? CNT_W'(31) : clb) + CNT_W'(unsigned_div);

  assign operand_zero_o = (popcnt == '0);

endmodule

`default_nettype wire

//--- logic/serial_divider.sv
/*
  serial_divider
  multi-cycle restoring divider on operand magnitudes, one
  quotient bit per cycle from a prealigned divisor, sign fixup
  and RISC-V zero-divisor result in the finish state
*/
`timescale 1ns/1ps
`default_nettype none

module serial_divider import alu_pkg::*; (
  input  logic              clk,
  input  logic              rst_i,
  input  logic              start_i,
  input  logic              signed_i,
  input  logic              rem_i,
  input  logic [DATA_W-1:0] dividend_i,
  input  logic [DATA_W-1:0] divisor_i,
  input  logic [CNT_W-1:0]  shift_i,
  input  logic              divisor_zero_i,
  input  logic              out_ready_i,
  output logic              valid_o,
  output logic [DATA_W-1:0] result_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_DIVIDE,
    S_FINISH
  } state_e;

  state_e            state_q;
  logic [CNT_W-1:0]  cnt_q;
  logic [DATA_W-1:0] rem_q;
  logic [DATA_W-1:0] quo_q;
  logic [DATA_W:0]   dsh_q;
  logic              neg_quo_q;
  logic              neg_rem_q;
  logic              zero_q;
  logic              sel_rem_q;
  logic              load;
  logic              fits;
  logic [DATA_W-1:0] dividend_mag;
  logic [DATA_W-1:0] divisor_mag;
  logic [DATA_W-1:0] quotient;
  logic [DATA_W-1:0] remainder;

  assign load = (state_q == S_IDLE) && start_i;

  // magnitudes, minimum negates onto itself and reads as 2^31
  assign dividend_mag = (signed_i && dividend_i[DATA_W-1]) ? -dividend_i : dividend_i;
  assign divisor_mag  = (signed_i && divisor_i[DATA_W-1]) ? -divisor_i : divisor_i;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst_i) begin
      state_q <= S_IDLE;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          if (start_i) begin
            state_q <= S_DIVIDE;
            // signed divisors sit one bit lower, so one extra step
            cnt_q   <= shift_i + CNT_W'(signed_i);
          end
        end
        S_DIVIDE: begin
          cnt_q <= cnt_q - CNT_W'(1);
          if (cnt_q == '0) state_q <= S_FINISH;
        end
        S_FINISH: begin
          // hold the result while the pipeline stalls
          if (out_ready_i) state_q <= S_IDLE;
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  //////////////////////////////////////////////////
  // datapath
  //////////////////////////////////////////////////
  // divisor register one bit wider, it may start at 2^32
  assign fits = {1'b0, rem_q} >= dsh_q;

  always_ff @(posedge clk) begin
    if (load) begin
      rem_q     <= dividend_mag;
      quo_q     <= '0;
      dsh_q     <= signed_i ? {divisor_mag, 1'b0} : {1'b0, divisor_mag};
      // aligned signed divisor still carries its sign in bit 31
      neg_quo_q <= signed_i & (dividend_i[DATA_W-1] ^ divisor_i[DATA_W-1]);
      neg_rem_q <= signed_i & dividend_i[DATA_W-1];
      zero_q    <= divisor_zero_i;
      sel_rem_q <= rem_i;
    end else if (state_q == S_DIVIDE) begin
      // restoring step, subtract only when it fits
      if (fits) rem_q <= rem_q - dsh_q[DATA_W-1:0];
      quo_q <= {quo_q[DATA_W-2:0], fits};
      dsh_q <= dsh_q >> 1;
    end
  end

  // min / -1 lands on min with remainder 0 without a special case
  assign quotient  = zero_q ? '1 : (neg_quo_q ? -quo_q : quo_q);
  // remainder follows the dividend sign, equals the dividend for a zero divisor
  assign remainder = neg_rem_q ? -rem_q : rem_q;

  assign result_o = sel_rem_q ? remainder : quotient;
  assign valid_o  = (state_q == S_FINISH);

endmodule

`default_nettype wire

//--- logic/simd_adder.sv
/*
  simd_adder
  partitioned adder/subtractor for one 32-bit, two 16-bit or
  four 8-bit lanes, with a spacer bit below each byte that passes,
  blocks or injects the carry into that byte
*/
`timescale 1ns/1ps
`default_nettype none

module simd_adder import alu_pkg::*; (
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  logic              negate_i,
  input  vec_mode_e         vector_mode_i,
  output logic [DATA_W-1:0] sum_o
);

  // one spacer bit per byte
  localparam int WIDE_W = DATA_W + LANES;

  logic [DATA_W-1:0] op_b;
  logic [WIDE_W-1:0] in_a;
  logic [WIDE_W-1:0] in_b;
  logic [WIDE_W-1:0] sum_wide;

  // inverted b for subtract, the +1 arrives through the spacers
  assign op_b = negate_i ? ~operand_b_i : operand_b_i;

  for (genvar i = 0; i < LANES; i++) begin : g_byte
    logic lane_start;

    // byte 0 always opens a lane
    // in 16-bit mode byte 2 does too, in 8-bit mode every byte
    assign lane_start = (i == 0) || (vector_mode_i == MODE8) ||
                        ((vector_mode_i == MODE16) && (i == 2));

    // spacer pair 1/0 passes the carry up
    // 0/0 at a lane start kills it for add
    // 1/1 at a lane start forces it for subtract
    assign in_a[9*i] = negate_i | ~lane_start;
    assign in_b[9*i] = negate_i & lane_start;

    assign in_a[9*i+1 +: 8] = operand_a_i[8*i +: 8];
    assign in_b[9*i+1 +: 8] = op_b[8*i +: 8];

    // drop the spacer positions on the way out
    assign sum_o[8*i +: 8] = sum_wide[9*i+1 +: 8];
  end

  // single carry chain, lanes kept apart by the spacers
  assign sum_wide = in_a + in_b;

endmodule

`default_nettype wire

//--- logic/simd_compare.sv
/*
  simd_compare
  per-byte equal and greater network merged into lane results,
  comparison mask for every compare kind, and byte-wise
  min/max selection from the merged greater flags
*/
`timescale 1ns/1ps
`default_nettype none

module simd_compare import alu_pkg::*; (
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  input  alu_op_e           operator_i,
  input  vec_mode_e         vector_mode_i,
  output logic [LANES-1:0]  cmp_mask_o,
  output logic [DATA_W-1:0] minmax_o
);

  logic             is_signed;
  logic             do_min;
  vec_mode_e        mode;
  logic [LANES-1:0] byte_signed;
  logic [LANES-1:0] eq_byte;
  logic [LANES-1:0] gt_byte;
  logic [LANES-1:0] is_equal;
  logic [LANES-1:0] is_greater;
  logic [LANES-1:0] sel_a;

  assign is_signed = operator_i inside {GTS, GES, LTS, LES, SLTS, MIN, MAX};
  assign do_min    = operator_i inside {MIN, MINU};

  // set-less-than is a scalar compare whatever the lane mode
  assign mode = (operator_i inside {SLTS, SLTU}) ? MODE32 : vector_mode_i;

  // sign only matters in the top byte of each lane
  always_comb begin
    case (mode)
      MODE8:   byte_signed = {LANES{is_signed}};
      MODE16:  byte_signed = {is_signed, 1'b0, is_signed, 1'b0};
      default: byte_signed = {is_signed, 3'b000};
    endcase
  end

  for (genvar i = 0; i < LANES; i++) begin : g_byte
    assign eq_byte[i] = operand_a_i[8*i +: 8] == operand_b_i[8*i +: 8];
    // 9-bit compare, extra bit is the sign for signed bytes
    assign gt_byte[i] = $signed({byte_signed[i] & operand_a_i[8*i+7], operand_a_i[8*i +: 8]}) >
                        $signed({byte_signed[i] & operand_b_i[8*i+7], operand_b_i[8*i +: 8]});
    // min/max picks whole bytes, lane flags are already spread
    assign minmax_o[8*i +: 8] = sel_a[i] ? operand_a_i[8*i +: 8] : operand_b_i[8*i +: 8];
  end

  //////////////////////////////////////////////////
  // lane merge, result repeated on each byte of its lane
  //////////////////////////////////////////////////
  always_comb begin
    case (mode)
      MODE8: begin
        is_equal   = eq_byte;
        is_greater = gt_byte;
      end
      MODE16: begin
        is_equal   = {{2{eq_byte[3] & eq_byte[2]}}, {2{eq_byte[1] & eq_byte[0]}}};
        is_greater = {{2{gt_byte[3] | (eq_byte[3] & gt_byte[2])}},
                      {2{gt_byte[1] | (eq_byte[1] & gt_byte[0])}}};
      end
      default: begin
        is_equal   = {LANES{&eq_byte}};
        // most significant differing byte decides
        is_greater = {LANES{gt_byte[3] | (eq_byte[3] & (gt_byte[2] |
                     (eq_byte[2] & (gt_byte[1] | (eq_byte[1] & gt_byte[0])))))}};
      end
    endcase
  end

  // compare kind
  always_comb begin
    case (operator_i)
      NE:                   cmp_mask_o = ~is_equal;
      GTS, GTU:             cmp_mask_o = is_greater;
      GES, GEU:             cmp_mask_o = is_greater | is_equal;
      LTS, LTU, SLTS, SLTU: cmp_mask_o = ~(is_greater | is_equal);
      LES, LEU:             cmp_mask_o = ~is_greater;
      default:              cmp_mask_o = is_equal;
    endcase
  end

  // a for max when greater, inverted sense for min
  assign sel_a = is_greater ^ {LANES{do_min}};

endmodule

`default_nettype wire

//--- logic/simd_shifter.sv
/*
  simd_shifter
  lane-aware right shifter; left shifts reverse the operand,
  shift right and reverse back, which also yields the prealigned
  divisor for the serial divider
*/
`timescale 1ns/1ps
`default_nettype none

module simd_shifter import alu_pkg::*; (
  input  logic [DATA_W-1:0] operand_i,
  input  logic [DATA_W-1:0] amount_i,
  input  shift_ctrl_t       ctrl_i,
  input  vec_mode_e         vector_mode_i,
  output logic [DATA_W-1:0] result_o,
  output logic [DATA_W-1:0] left_result_o
);

  logic [DATA_W-1:0]   op_rev;
  logic [DATA_W-1:0]   src;
  logic [DATA_W-1:0]   amt;
  logic [2*DATA_W-1:0] wide;
  logic [DATA_W-1:0]   shr;

  assign op_rev = {<<{operand_i}};
  assign src    = ctrl_i.left ? op_rev : operand_i;

  // reversing the word also reverses lane order
  // so each lane must take the amount field of its mirror lane
  always_comb begin
    amt = amount_i;
    if (ctrl_i.left) begin
      case (vector_mode_i)
        MODE16:  amt = {amount_i[15:0], amount_i[31:16]};
        MODE8:   amt = {amount_i[7:0], amount_i[15:8], amount_i[23:16], amount_i[31:24]};
        default: amt = amount_i;
      endcase
    end
  end

  // doubled word for rotate, else sign or zero fill above
  assign wide = ctrl_i.rotate ? {src, src} : {{DATA_W{ctrl_i.arith & src[DATA_W-1]}}, src};

  always_comb begin
    shr = '0;
    case (vector_mode_i)
      MODE16: begin
        // low 4 bits of each halfword amount
        for (int h = 0; h < 2; h++) begin
          shr[16*h +: 16] = 16'($signed({ctrl_i.arith & src[16*h+15], src[16*h +: 16]})
                                >>> amt[16*h +: 4]);
        end
      end
      MODE8: begin
        // low 3 bits of each byte amount
        for (int b = 0; b < LANES; b++) begin
          shr[8*b +: 8] = 8'($signed({ctrl_i.arith & src[8*b+7], src[8*b +: 8]})
                             >>> amt[8*b +: 3]);
        end
      end
      default: shr = DATA_W'(wide >> amt[4:0]);
    endcase
  end

  // mirror back, divider takes this as its aligned divisor
  assign left_result_o = {<<{shr}};
  assign result_o      = ctrl_i.left ? left_result_o : shr;

endmodule

`default_nettype wire

//--- tb/alu_assertions.sv
/*
  alu_assertions
  concurrent checks on the serial divider, bound into every
  serial_divider instance
*/
`timescale 1ns/1ps
`default_nettype none

module alu_assertions import alu_pkg::*; (
  input logic              clk,
  input logic              rst_i,
  input logic              load_i,
  input logic              valid_i,
  input logic              out_ready_i,
  input logic [DATA_W-1:0] result_i
);

  // failed assertions, watched by the testbench every cycle
  int unsigned failures = 0;
  logic [6:0]  busy_cycles;

  // cycles spent dividing since the last load
  always_ff @(posedge clk) begin
    if (rst_i || valid_i) begin
      busy_cycles <= '0;
    end else if (load_i || busy_cycles != '0) begin
      busy_cycles <= busy_cycles + 7'd1;
    end
  end

  valid_known: assert property (@(posedge clk) disable iff (rst_i) !$isunknown(valid_i))
    else begin
      $error("divider valid_o is unknown");
      failures++;
    end

  // stalled finish keeps the result on the output
  finish_hold: assert property (@(posedge clk) disable iff (rst_i)
    (valid_i && !out_ready_i) |=> (valid_i && $stable(result_i)))
    else begin
      $error("divider result changed or valid_o dropped under back-pressure");
      failures++;
    end

  busy_limit: assert property (@(posedge clk) disable iff (rst_i) busy_cycles <= 7'd34)
    else begin
      $error("divider busy for more than 34 cycles");
      failures++;
    end

endmodule

`default_nettype wire

//--- tb/alu_tb.sv
/*
  alu_tb
  directed and xorshift random stimulus for the SIMD integer ALU,
  every result checked against a behavioral model, with a cycle
  limit on the whole run
*/
`timescale 1ns/1ps
`default_nettype none

module alu_tb import alu_pkg::*; ();

  localparam int NUM_OPS    = 600;
  // a division takes under 40 cycles, everything else one
  localparam int MAX_CYCLES = NUM_OPS * 40;

  logic              clk;
  logic              rst_i;
  logic              enable_i;
  alu_req_t          req_i;
  logic              ex_ready_i;
  logic [DATA_W-1:0] result_o;
  logic              comparison_result_o;
  logic              ready_o;
  logic [31:0]       rng_state;
  int                cycles;

  alu_top uut (
    .clk                 (clk),
    .rst_i               (rst_i),
    .enable_i            (enable_i),
    .req_i               (req_i),
    .ex_ready_i          (ex_ready_i),
    .result_o            (result_o),
    .comparison_result_o (comparison_result_o),
    .ready_o             (ready_o)
  );

  bind serial_divider alu_assertions u_div_checks (
    .clk         (clk),
    .rst_i       (rst_i),
    .load_i      (load),
    .valid_i     (valid_o),
    .out_ready_i (out_ready_i),
    .result_i    (result_o)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("run went past %0d cycles without finishing", MAX_CYCLES);
      $display("TESTS FAILED");
      $fatal(1, "timeout");
    end
  end

  // divider checker failures end the run on the next edge
  always @(posedge clk) begin
    assert (uut.u_divider.u_div_checks.failures == 0)
      else fail_plain("a divider assertion failed");
  end

  //////////////////////////////////////////////////
  // random numbers
  //////////////////////////////////////////////////
  function automatic logic [31:0] xorshift32(logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // leans on zero, all ones, the signed minimum and tiny values
  function automatic logic [31:0] pick_operand();
    logic [31:0] r;
    logic [31:0] v;
    r = next_rand();
    case (r[2:0])
      3'd0:    v = 32'h0000_0000;
      3'd1:    v = 32'hffff_ffff;
      3'd2:    v = 32'h8000_0000;
      3'd3:    v = {28'h0, r[31:28]};
      default: v = next_rand();
    endcase
    return v;
  endfunction

  //////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////
  // lane value widened to 33 bits, sign extended when asked
  function automatic logic signed [32:0] lane_val(logic [31:0] x, int w, logic sgn);
    logic [32:0] v;
    v = {1'b0, x};
    if (sgn && x[w-1]) v = v - (33'd1 << w);
    return $signed(v);
  endfunction

  function automatic logic [31:0] model_result(alu_op_e op, vec_mode_e mode,
                                               logic [31:0] a, logic [31:0] b);
    int                 w;
    int                 sh;
    logic               sgn;
    logic               hit;
    logic [31:0]        mask;
    logic [31:0]        la;
    logic [31:0]        lb;
    logic [31:0]        lr;
    logic signed [32:0] va;
    logic signed [32:0] vb;
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [31:0]        r;
    r   = '0;
    hit = 1'b0;
    sa  = a;
    sb  = b;
    w   = (mode == MODE8) ? 8 : (mode == MODE16) ? 16 : 32;
    // set-less-than is a scalar compare
    if (op inside {SLTS, SLTU}) w = 32;
    mask = (w == 32) ? 32'hffff_ffff : ((32'd1 << w) - 32'd1);
    sgn  = op inside {GTS, GES, LTS, LES, SLTS, MIN, MAX, SRA};
    case (op)
      AND: r = a & b;
      OR:  r = a | b;
      XOR: r = a ^ b;
      FF1: begin
        r = 32;
        for (int i = 31; i >= 0; i--) if (a[i]) r = i;
      end
      FL1: begin
        r = 32;
        for (int i = 0; i < 32; i++) if (a[i]) r = i;
      end
      CNT: begin
        for (int i = 0; i < 32; i++) r = r + 32'(a[i]);
      end
      CLB: begin
        // leading copies of the sign bit minus one, zero stays 0
        if (a != '0) begin
          for (int i = 31; i >= 0; i--) begin
            if (a[i] != a[31]) hit = 1'b1;
            if (!hit) r = r + 32'd1;
          end
          r = r - 32'd1;
        end
      end
      // b is the dividend, a the divisor
      DIVU: r = (a == '0) ? 32'hffff_ffff : b / a;
      REMU: r = (a == '0) ? b : b % a;
      DIV: begin
        if (a == '0) r = 32'hffff_ffff;
        else if (b == 32'h8000_0000 && a == 32'hffff_ffff) r = b;
        else r = sb / sa;
      end
      REM: begin
        if (a == '0) r = b;
        else if (b == 32'h8000_0000 && a == 32'hffff_ffff) r = '0;
        else r = sb % sa;
      end
      default: begin
        for (int k = 0; k < 32 / w; k++) begin
          la = (a >> (k * w)) & mask;
          lb = (b >> (k * w)) & mask;
          va = lane_val(la, w, sgn);
          vb = lane_val(lb, w, sgn);
          sh = int'(lb & 32'(w - 1));
          case (op)
            ADD:                lr = la + lb;
            SUB:                lr = la - lb;
            SLL:                lr = la << sh;
            SRL:                lr = la >> sh;
            SRA:                lr = 32'(va >>> sh);
            // only driven in 32-bit mode
            ROR:                lr = (la >> sh) | (la << (32 - sh));
            EQ:                 lr = (va == vb) ? mask : '0;
            NE:                 lr = (va != vb) ? mask : '0;
            GTS, GTU:           lr = (va > vb) ? mask : '0;
            GES, GEU:           lr = (va >= vb) ? mask : '0;
            LTS, LTU:           lr = (va < vb) ? mask : '0;
            LES, LEU:           lr = (va <= vb) ? mask : '0;
            SLTS, SLTU:         lr = (va < vb) ? 32'd1 : 32'd0;
            MIN, MINU:          lr = (va < vb) ? la : lb;
            MAX, MAXU:          lr = (va > vb) ? la : lb;
            default:            lr = '0;
          endcase
          r = r | ((lr & mask) << (k * w));
        end
      end
    endcase
    return r;
  endfunction

  //////////////////////////////////////////////////
  // checks and drivers
  //////////////////////////////////////////////////
  task automatic fail_value(string name, logic [31:0] exp, logic [31:0] act);
    $display("** Error %s: expected %h, actual %h", name, exp, act);
    $display("TESTS FAILED");
    $fatal(1, "value mismatch");
  endtask

  task automatic fail_plain(string what);
    $display("** Error %s", what);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic drive_req(alu_op_e op, vec_mode_e mode, logic [31:0] a, logic [31:0] b);
    req_i.operator    = op;
    req_i.vector_mode = mode;
    req_i.operand_a   = a;
    req_i.operand_b   = b;
    enable_i          = 1'b1;
  endtask

  task automatic run_comb(alu_op_e op, vec_mode_e mode, logic [31:0] a, logic [31:0] b);
    logic [31:0] exp;
    logic        cmp_exp;
    string       name;
    exp     = model_result(op, mode, a, b);
    cmp_exp = (op inside {SLTS, SLTU}) ? exp[0] : exp[31];
    name    = $sformatf("%s/%s a=%h b=%h", op.name(), mode.name(), a, b);
    @(posedge clk);
    #1;
    drive_req(op, mode, a, b);
    @(negedge clk);
    assert (result_o === exp) else fail_value(name, exp, result_o);
    assert (ready_o === 1'b1) else fail_plain({name, ": ready_o low on a one-cycle op"});
    // mask top lane doubles as the branch flag
    if (op inside {EQ, NE, GTS, GTU, GES, GEU, LTS, LTU, LES, LEU, SLTS, SLTU}) begin
      assert (comparison_result_o === cmp_exp)
        else fail_value({name, " comparison_result_o"}, 32'(cmp_exp), 32'(comparison_result_o));
    end
  endtask

  task automatic run_div(alu_op_e op, logic [31:0] a, logic [31:0] b);
    logic [31:0] exp;
    string       name;
    int          hold;
    exp  = model_result(op, MODE32, a, b);
    name = $sformatf("%s a=%h b=%h", op.name(), a, b);
    // stall cycles in finish, 0 leaves at once
    hold = int'(next_rand() % 32'd4);
    @(posedge clk);
    #1;
    drive_req(op, MODE32, a, b);
    ex_ready_i = (hold == 0);
    @(negedge clk);
    assert (ready_o === 1'b0) else fail_plain({name, ": ready_o stayed high on a division"});
    while (ready_o !== 1'b1) @(negedge clk);
    assert (result_o === exp) else fail_value(name, exp, result_o);
    if (hold > 0) begin
      repeat (hold - 1) begin
        @(negedge clk);
        assert (ready_o === 1'b1 && result_o === exp)
          else fail_value({name, " under back-pressure"}, exp, result_o);
      end
      @(posedge clk);
      #1;
      ex_ready_i = 1'b1;
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////
  initial begin
    int          idx;
    alu_op_e     op;
    vec_mode_e   mode;
    logic [31:0] a;
    logic [31:0] b;
    clk        = 1'b0;
    rst_i      = 1'b1;
    enable_i   = 1'b0;
    ex_ready_i = 1'b1;
    req_i      = '0;
    cycles     = 0;
    rng_state  = 32'h362b_b184;
    repeat (2) @(posedge clk);
    #1;
    rst_i = 1'b0;
    assert (ready_o === 1'b1) else fail_plain("ready_o low right after reset");

    // corner cases first
    run_div(DIV, 32'hffff_ffff, 32'h8000_0000);
    run_div(REM, 32'hffff_ffff, 32'h8000_0000);
    run_div(DIVU, 32'h0000_0000, 32'h1234_5678);
    run_div(REM, 32'h0000_0000, 32'hf000_0001);
    run_comb(FF1, MODE32, 32'h0000_0000, 32'h0000_0000);
    run_comb(FL1, MODE32, 32'h0000_0000, 32'h0000_0000);
    run_comb(CLB, MODE32, 32'hffff_ffff, 32'h0000_0000);
    run_comb(CLB, MODE32, 32'h0000_0000, 32'h0000_0000);

    for (int n = 0; n < NUM_OPS; n++) begin
      idx  = int'(next_rand() % 32'd33);
      // codes 29 to 31 are unused
      op   = (idx < 29) ? alu_op_e'(6'(idx)) : alu_op_e'(6'(idx + 3));
      idx  = int'(next_rand() % 32'd3);
      mode = (idx == 0) ? MODE32 : (idx == 1) ? MODE16 : MODE8;
      if (op == ROR) mode = MODE32;
      a = pick_operand();
      b = pick_operand();
      if (is_div_op(op)) run_div(op, a, b);
      else run_comb(op, mode, a, b);
    end

    @(posedge clk);
    if (uut.u_divider.u_div_checks.failures != 0) begin
      $display("divider assertions failed %0d times", uut.u_divider.u_div_checks.failures);
      $display("TESTS FAILED");
      $fatal(1, "assertion failures");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire
